//--- tank_bot_top.f
+incdir+include
hdl/tank_geom_pkg.sv
hdl/tank_ctrl_pkg.sv
hdl/wall_sensor.sv
hdl/tank_motion.sv
hdl/bot_pilot.sv
hdl/bullet_unit.sv
hdl/sprite_render.sv
hdl/tank_bot_top.sv
verification/tank_bot_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the tank testbench with verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tank_bot_tb \
    -f tank_bot_top.f -o tank_bot_sim > build.log 2>&1 \
    && ./obj_dir/tank_bot_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation aborted"; exit 1; }

cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1 || exit 0

//--- include/tank_bot_tests.svh
// tank bot directed tests
`ifndef TANK_BOT_TESTS_SVH
`define TANK_BOT_TESTS_SVH

task automatic probe_box(input int h, input int v, input logic exp);
    set_scan(h, v);
    if (tank_enable_o !== exp) report_mismatch("tank_enable_o", tank_enable_o, exp);
endtask

// box spans offsets 1..29, so probe just inside and just outside each edge
task automatic expect_box(input int x, input int y);
    probe_box(x + 1, y + 15, 1'b1);
    probe_box(x, y + 15, 1'b0);
    probe_box(x + 29, y + 15, 1'b1);
    probe_box(x + 30, y + 15, 1'b0);
    probe_box(x + 15, y + 1, 1'b1);
    probe_box(x + 15, y, 1'b0);
    probe_box(x + 15, y + 29, 1'b1);
    probe_box(x + 15, y + 30, 1'b0);
endtask

// a move lands on the tick after the autopilot outputs the direction
task automatic track_moves(input int n, input int first_drive, input bit horiz);
    int t;
    int phase;
    bit moving;
    bit was_moving;
    phase  = 0;
    moving = 1'b0;
    for (t = 0; t < n; t++) begin
        give_tick(1'b0);
        was_moving = moving;
        if (phase >= first_drive && phase < first_drive + 4) moving = 1'b1;
        if (phase >= first_drive + 4 && tank_x % 16 <= 1 && tank_y % 16 <= 1) begin
            moving = 1'b0;  // settled on the grid and back to planning
            phase  = -1;
        end
        if (was_moving && horiz) tank_x++;
        if (was_moving && !horiz) tank_y++;
        phase++;
        expect_box(tank_x, tank_y);
    end
endtask

task automatic read_addr(input int tx, input int ty, input int c, output logic [9:0] addr);
    int h;
    @(negedge clk_i);
    scan_i  = '{hpos: 10'd0, vpos: 10'(ty)};
    hsync_i = 1'b1;  // line start on the first tank row
    for (h = 0; h <= c; h++) begin
        @(negedge clk_i);
        hsync_i     = 1'b0;
        scan_i.hpos = 10'(tx + h);
    end
    @(negedge clk_i);
    addr = gfx_addr_o;
endtask

// column counter restarts at 2 on the origin pixel and runs one ahead of the offset
// row counter restarts at 2 on the first tank line
task automatic check_addr(input int c, input bit horiz);
    logic [9:0] got;
    logic [9:0] exp;
    read_addr(tank_x, tank_y, c, got);
    if (horiz) begin
        exp = {5'd2, 5'(c + 1)};  // {row, col}
    end else begin
        exp = {5'(c + 1), 5'd2};  // {col, row}
    end
    if (got !== exp) report_mismatch("gfx_addr_o", got, exp);
endtask

////////////////////////////////////////////////////////////
// directed tests

task automatic reset_view();
    set_scan(tank_x + 15, tank_y + 15);
    if (bullet_enable_o !== 1'b0) report_mismatch("bullet_enable_o", bullet_enable_o, 0);
    if (tank_enable_o !== 1'b1) report_mismatch("tank_enable_o", tank_enable_o, 1);
    if (pixel_o !== gfx_pixel_i) report_mismatch("pixel_o", pixel_o, gfx_pixel_i);
    set_scan(tank_x, tank_y);
    if (tank_enable_o !== 1'b0) report_mismatch("tank_enable_o", tank_enable_o, 0);
    if (pixel_o !== '0) report_mismatch("pixel_o", pixel_o, 0);
    set_scan(tank_x + 30, tank_y);
    if (tank_enable_o !== 1'b0) report_mismatch("tank_enable_o", tank_enable_o, 0);
endtask

task automatic down_run();
    track_moves(24, 2, 1'b0);  // runs past one grid stop
endtask

task automatic right_turn();
    @(negedge clk_i);
    block_i = 1'b1;
    scan_i  = '{hpos: 10'(tank_x + 15), vpos: 10'(tank_y + 32)};  // bottom edge line
    @(negedge clk_i);
    block_i = 1'b0;
    track_moves(12, 3, 1'b1);  // one extra check tick while blocked
endtask

task automatic sprite_down();
    check_addr(5, 1'b0);
    check_addr(6, 1'b0);
endtask

task automatic sprite_right();
    check_addr(5, 1'b1);
endtask

task automatic bullet_flight();
    int bx;
    int by;
    int wait_cnt;
    int i;
    bx = tank_x + 14;  // nose of a tank facing down
    by = tank_y + 32;
    @(negedge clk_i);
    fire_i   = 1'b1;
    wait_cnt = 0;
    set_scan(bx, by);
    while (bullet_enable_o !== 1'b1 && wait_cnt < 20) begin
        set_scan(bx, by);
        wait_cnt++;
    end
    if (bullet_enable_o !== 1'b1) begin
        tmo_cnt++;
        $display("bullet never showed up at its spawn square");
    end
    @(negedge clk_i);
    fire_i = 1'b0;
    set_scan(bx + 4, by + 4);
    if (bullet_enable_o !== 1'b1) report_mismatch("bullet_enable_o", bullet_enable_o, 1);
    set_scan(bx + 5, by);
    if (bullet_enable_o !== 1'b0) report_mismatch("bullet_enable_o", bullet_enable_o, 0);
    repeat (3) give_tick(1'b1);
    by = by + 3;
    set_scan(bx, by);
    if (bullet_enable_o !== 1'b1) report_mismatch("bullet_enable_o", bullet_enable_o, 1);
    set_scan(bx, by - 1);
    if (bullet_enable_o !== 1'b0) report_mismatch("bullet_enable_o", bullet_enable_o, 0);
    @(negedge clk_i);
    hit_i = 1'b1;
    @(negedge clk_i);
    hit_i = 1'b0;
    for (i = 0; i < 4; i++) begin
        set_scan(bx + 2, by + 2 - i);
        if (bullet_enable_o !== 1'b0) report_mismatch("bullet_enable_o", bullet_enable_o, 0);
    end
endtask

task automatic death_gating();
    int i;
    @(negedge clk_i);
    tank_die_i = 1'b1;
    set_scan(tank_x + 15, tank_y + 15);
    if (tank_enable_o !== 1'b0) report_mismatch("tank_enable_o", tank_enable_o, 0);
    if (pixel_o !== '0) report_mismatch("pixel_o", pixel_o, 0);
    @(negedge clk_i);
    fire_i = 1'b1;
    for (i = 0; i < 10; i++) begin
        set_scan(tank_x + 16, tank_y + 34);  // middle of the spawn square
        if (bullet_enable_o !== 1'b0) report_mismatch("bullet_enable_o", bullet_enable_o, 0);
    end
    @(negedge clk_i);
    fire_i     = 1'b0;
    tank_die_i = 1'b0;
endtask

`endif

//--- verification/tank_bot_tb.sv
// tank bot testbench
`timescale 1ns/1ps

module tank_bot_tb
    import tank_geom_pkg::*, tank_ctrl_pkg::*;
();

    logic       clk_i, reset_tank;
    logic       player_tick_i, bullet_tick_i, hsync_i;
    scan_pos_t  scan_i;
    logic       block_i, fire_i, hit_i, tank_die_i;
    rgb_t       gfx_pixel_i, pixel_o;
    logic [9:0] gfx_addr_o;
    logic       tank_enable_o, bullet_enable_o;

    int         err_cnt;
    int         tmo_cnt;
    int         tank_x, tank_y;  // expected tank origin

    tank_bot_top u_tank_bot_top (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    ////////////////////////////////////////////////////////////
    // stimulus helpers

    task automatic apply_reset();
        @(negedge clk_i);
        reset_tank = 1'b1;
        repeat (5) @(negedge clk_i);
        reset_tank = 1'b0;
        tank_x = 32;
        tank_y = 416;
    endtask

    // one scan pixel, held until the outputs settle
    task automatic set_scan(input int h, input int v);
        @(negedge clk_i);
        scan_i = '{hpos: 10'(h), vpos: 10'(v)};
        #1;
    endtask

    task automatic give_tick(input bit bullet);
        repeat ($urandom_range(3, 0)) @(negedge clk_i);  // idle gap
        @(negedge clk_i);
        if (bullet) bullet_tick_i = 1'b1;
        else player_tick_i = 1'b1;
        @(negedge clk_i);
        bullet_tick_i = 1'b0;
        player_tick_i = 1'b0;
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        err_cnt++;
        $display("FAIL %s got %h expected %h at %0t", name, got, exp, $time);
    endtask

    `include "tank_bot_tests.svh"

    ////////////////////////////////////////////////////////////
    // test sequence

    initial begin
        void'($urandom(32'h80d5));
        err_cnt       = 0;
        tmo_cnt       = 0;
        reset_tank    = 1'b1;
        player_tick_i = 1'b0;
        bullet_tick_i = 1'b0;
        hsync_i       = 1'b0;
        scan_i        = '0;
        block_i       = 1'b0;
        fire_i        = 1'b0;
        hit_i         = 1'b0;
        tank_die_i    = 1'b0;
        gfx_pixel_i   = 24'h5a3cc9;

        apply_reset();
        reset_view();
        sprite_down();
        down_run();
        apply_reset();
        right_turn();
        sprite_right();
        apply_reset();
        bullet_flight();
        death_gating();

        $display("mismatches: %0d  timeouts: %0d", err_cnt, tmo_cnt);
        if (err_cnt == 0 && tmo_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- hdl/tank_bot_top.sv
// enemy tank top level
`timescale 1ns/1ps

module tank_bot_top import tank_geom_pkg::*, tank_ctrl_pkg::*; #(
    parameter coord_t TANK_X_INIT   = 10'd32,
    parameter coord_t TANK_Y_INIT   = 10'd416,
    parameter dir_t   TANK_DIR_INIT = DIR_DOWN,
    parameter coord_t MOVE_STEP     = 10'd1,
    parameter coord_t BULLET_STEP   = 10'd1,
    parameter int     SETTLE_LIMIT  = 200,
    parameter int     DRIVE_TICKS   = 4
) (
    input  logic       clk_i,
    input  logic       reset_tank,
    input  logic       player_tick_i,
    input  logic       bullet_tick_i,
    input  logic       hsync_i,
    input  scan_pos_t  scan_i,
    input  logic       block_i,
    input  logic       fire_i,
    input  logic       hit_i,
    input  logic       tank_die_i,
    input  rgb_t       gfx_pixel_i,
    output logic [9:0] gfx_addr_o,
    output rgb_t       pixel_o,
    output logic       tank_enable_o,
    output logic       bullet_enable_o
);

    tank_state_t tank;
    wall_flags_t walls;
    dir_t        move_dir;

    wall_sensor u_wall_sensor (
        .clk_i, .reset_tank, .scan_i, .tank_i(tank), .move_dir_i(move_dir),
        .block_i, .walls_o(walls));

    tank_motion #(.TANK_X_INIT(TANK_X_INIT), .TANK_Y_INIT(TANK_Y_INIT),
        .TANK_DIR_INIT(TANK_DIR_INIT), .MOVE_STEP(MOVE_STEP)) u_tank_motion (
        .clk_i, .reset_tank, .player_tick_i, .move_dir_i(move_dir),
        .walls_i(walls), .tank_o(tank));

    bot_pilot #(.SETTLE_LIMIT(SETTLE_LIMIT), .DRIVE_TICKS(DRIVE_TICKS)) u_bot_pilot (
        .clk_i, .reset_tank, .player_tick_i, .tank_i(tank), .walls_i(walls),
        .move_dir_o(move_dir));

    bullet_unit #(.BULLET_STEP(BULLET_STEP)) u_bullet_unit (
        .clk_i, .reset_tank, .bullet_tick_i, .fire_i, .hit_i, .tank_die_i,
        .tank_i(tank), .scan_i, .bullet_enable_o);

    sprite_render u_sprite_render (
        .clk_i, .reset_tank, .hsync_i, .scan_i, .tank_i(tank), .tank_die_i,
        .gfx_pixel_i, .gfx_addr_o, .pixel_o, .tank_enable_o);

endmodule

//--- hdl/sprite_render.sv
// tank sprite renderer
`timescale 1ns/1ps

module sprite_render import tank_geom_pkg::*, tank_ctrl_pkg::*; (
    input  logic        clk_i,
    input  logic        reset_tank,
    input  logic        hsync_i,
    input  scan_pos_t   scan_i,
    input  tank_state_t tank_i,
    input  logic        tank_die_i,
    input  rgb_t        gfx_pixel_i,
    output logic [9:0]  gfx_addr_o,
    output rgb_t        pixel_o,
    output logic        tank_enable_o
);

    logic         hsync_q, line_start, box;
    sprite_ofs_t  xofs, xofs_bwd, yofs, yofs_bwd;
    coord_t       hofs, vofs;
    sprite_addr_u addr;

    assign line_start = hsync_i && !hsync_q;

    always_ff @(posedge clk_i or posedge reset_tank) begin
        if (reset_tank) begin
            hsync_q  <= 1'b0;
            yofs     <= '0;
            yofs_bwd <= '0;
            xofs     <= '0;
            xofs_bwd <= '0;
        end else begin
            hsync_q <= hsync_i;
            if (line_start) begin  // rows
                yofs     <= (scan_i.vpos == tank_i.y) ? 5'd2  : yofs + (yofs != 5'd31);
                yofs_bwd <= (scan_i.vpos == tank_i.y) ? 5'd30 : yofs_bwd - (yofs_bwd != 5'd0);
            end
            xofs     <= (scan_i.hpos == tank_i.x) ? 5'd2  : xofs + (xofs != 5'd31);
            xofs_bwd <= (scan_i.hpos == tank_i.x) ? 5'd31 : xofs_bwd - (xofs_bwd != 5'd0);
        end
    end

    ////////////////////////////////////////////////////////////
    // rotation, backward counters mirror up and left
    always_comb begin
        case (tank_i.facing)
            DIR_UP:    addr.vert = '{col: xofs, row: yofs_bwd};
            DIR_RIGHT: addr.horz = '{row: yofs, col: xofs};
            DIR_LEFT:  addr.horz = '{row: yofs, col: xofs_bwd};
            default:   addr.vert = '{col: xofs, row: yofs};
        endcase
    end

    always_ff @(posedge clk_i or posedge reset_tank) begin
        if (reset_tank) gfx_addr_o <= '0;
        else            gfx_addr_o <= addr;
    end

    assign hofs = scan_i.hpos - tank_i.x;
    assign vofs = scan_i.vpos - tank_i.y;
    assign box  = (hofs != '0) && (hofs < BOX_LIMIT) && (vofs != '0) && (vofs < BOX_LIMIT);

    assign tank_enable_o = box && !tank_die_i;
    assign pixel_o = tank_enable_o ? gfx_pixel_i : '0;

endmodule

//--- hdl/bullet_unit.sv
// tank bullet
`timescale 1ns/1ps

module bullet_unit import tank_geom_pkg::*, tank_ctrl_pkg::*; #(
    parameter coord_t BULLET_STEP = 10'd1
) (
    input  logic        clk_i,
    input  logic        reset_tank,
    input  logic        bullet_tick_i,
    input  logic        fire_i,
    input  logic        hit_i,
    input  logic        tank_die_i,
    input  tank_state_t tank_i,
    input  scan_pos_t   scan_i,
    output logic        bullet_enable_o
);

    bullet_state_e state;
    logic          fire_q, fire_rise, show;
    coord_t        bx, by;
    coord_t        hofs, vofs;
    dir_t          bdir;

    assign fire_rise = fire_i && !fire_q;

    ////////////////////////////////////////////////////////////
    // bullet FSM
    always_ff @(posedge clk_i or posedge reset_tank) begin
        if (reset_tank) begin
            state  <= IDLE;
            show   <= 1'b0;
            fire_q <= 1'b0;
        end else begin
            fire_q <= fire_i;
            case (state)
                IDLE: begin
                    show <= 1'b0;
                    if (fire_rise && !tank_die_i) state <= FLYING;
                end
                FLYING: begin
                    show <= !hit_i;
                    if (hit_i) state <= HIT;
                end
                default: state <= IDLE;  // one cycle after a hit
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // position, parked at the nose until launch
    always_ff @(posedge clk_i) begin
        if (state == IDLE) begin
            bdir <= tank_i.facing;
            case (tank_i.facing)
                DIR_UP: begin
                    bx <= tank_i.x + NOSE_OFS;
                    by <= tank_i.y - (BULLET_SIZE - 10'd1);
                end
                DIR_RIGHT: begin
                    bx <= tank_i.x + TANK_SIZE;
                    by <= tank_i.y + NOSE_OFS;
                end
                DIR_LEFT: begin
                    bx <= tank_i.x - (BULLET_SIZE - 10'd1);
                    by <= tank_i.y + NOSE_OFS;
                end
                default: begin  // down
                    bx <= tank_i.x + NOSE_OFS;
                    by <= tank_i.y + TANK_SIZE;
                end
            endcase
        end else if (state == FLYING && show && bullet_tick_i) begin
            case (bdir)
                DIR_DOWN:  by <= by + BULLET_STEP;
                DIR_UP:    by <= by - BULLET_STEP;
                DIR_RIGHT: bx <= bx + BULLET_STEP;
                DIR_LEFT:  bx <= bx - BULLET_STEP;
                default: ;
            endcase
        end
    end

    assign hofs = scan_i.hpos - bx;
    assign vofs = scan_i.vpos - by;
    assign bullet_enable_o = show && (hofs < BULLET_SIZE) && (vofs < BULLET_SIZE);

endmodule

//--- hdl/bot_pilot.sv
// tank autopilot
`timescale 1ns/1ps

module bot_pilot import tank_geom_pkg::*, tank_ctrl_pkg::*; #(
    parameter int SETTLE_LIMIT = 200,
    parameter int DRIVE_TICKS  = 4
) (
    input  logic        clk_i,
    input  logic        reset_tank,
    input  logic        player_tick_i,
    input  tank_state_t tank_i,
    input  wall_flags_t walls_i,
    output dir_t        move_dir_o
);

    localparam int DW = $clog2(DRIVE_TICKS + 1);
    localparam int SW = $clog2(SETTLE_LIMIT + 1);

    pilot_state_e   state;
    pilot_heading_e heading, chk_heading, turn_heading;
    dir_t           planned, chk_dir;
    logic           chk_go, aligned;
    logic [DW-1:0]  drive_cnt;
    logic [SW-1:0]  settle_cnt;

    assign turn_heading = (tank_i.x < SCREEN_MID) ? H_RIGHT : H_LEFT;
    assign aligned = ((tank_i.x % GRID) <= 10'd1) && ((tank_i.y % GRID) <= 10'd1);

    ////////////////////////////////////////////////////////////
    // heading choice
    always_comb begin
        chk_heading = heading;
        chk_go      = 1'b0;
        chk_dir     = DIR_STOP;
        if (!walls_i.bottom) begin  // down always wins
            chk_heading = H_DOWN;
            chk_go      = 1'b1;
            chk_dir     = DIR_DOWN;
        end else begin
            case (heading)
                H_LEFT:
                    if (!walls_i.left) begin
                        chk_go = 1'b1; chk_dir = DIR_LEFT;
                    end else if (!walls_i.right) begin
                        chk_heading = H_RIGHT; chk_go = 1'b1; chk_dir = DIR_RIGHT;
                    end else chk_heading = H_UP;
                H_RIGHT:
                    if (!walls_i.right) begin
                        chk_go = 1'b1; chk_dir = DIR_RIGHT;
                    end else if (!walls_i.left) begin
                        chk_heading = H_LEFT; chk_go = 1'b1; chk_dir = DIR_LEFT;
                    end else chk_heading = H_UP;
                H_UP:
                    if (!walls_i.top) begin
                        chk_go = 1'b1; chk_dir = DIR_UP;
                    end else chk_heading = turn_heading;
                default: chk_heading = turn_heading;  // down but blocked
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // stepped on player ticks only
    always_ff @(posedge clk_i or posedge reset_tank) begin
        if (reset_tank) begin
            state      <= PLAN;
            heading    <= H_DOWN;
            planned    <= DIR_STOP;
            move_dir_o <= DIR_STOP;
            drive_cnt  <= '0;
            settle_cnt <= '0;
        end else if (player_tick_i) begin
            case (state)
                PLAN: state <= CHECK;
                CHECK: begin
                    heading   <= chk_heading;
                    drive_cnt <= '0;
                    if (chk_go) begin
                        planned <= chk_dir;
                        state   <= DRIVE;
                    end
                end
                DRIVE: begin
                    move_dir_o <= planned;
                    drive_cnt  <= drive_cnt + 1'b1;
                    settle_cnt <= '0;
                    if (drive_cnt == DW'(DRIVE_TICKS - 1)) state <= SETTLE;
                end
                default: begin  // settle onto the grid
                    if (aligned) begin
                        move_dir_o <= DIR_STOP;
                        state      <= PLAN;
                    end else begin
                        settle_cnt <= settle_cnt + 1'b1;
                        if (settle_cnt == SW'(SETTLE_LIMIT)) state <= PLAN;
                    end
                end
            endcase
        end
    end

    a_move_dir_onehot0: assert property (
        @(posedge clk_i) disable iff (reset_tank) $onehot0(move_dir_o));

endmodule

//--- hdl/tank_motion.sv
// tank position and facing
`timescale 1ns/1ps

module tank_motion import tank_geom_pkg::*, tank_ctrl_pkg::*; #(
    parameter coord_t TANK_X_INIT   = 10'd32,
    parameter coord_t TANK_Y_INIT   = 10'd416,
    parameter dir_t   TANK_DIR_INIT = DIR_DOWN,
    parameter coord_t MOVE_STEP     = 10'd1
) (
    input  logic        clk_i,
    input  logic        reset_tank,
    input  logic        player_tick_i,
    input  dir_t        move_dir_i,
    input  wall_flags_t walls_i,
    output tank_state_t tank_o
);

    always_ff @(posedge clk_i or posedge reset_tank) begin
        if (reset_tank) begin
            tank_o <= '{x: TANK_X_INIT, y: TANK_Y_INIT, facing: TANK_DIR_INIT};
        end else if (player_tick_i) begin
            case (move_dir_i)
                DIR_DOWN: if (!walls_i.bottom) begin
                    tank_o.y      <= tank_o.y + MOVE_STEP;
                    tank_o.facing <= DIR_DOWN;
                end
                DIR_UP: if (!walls_i.top) begin
                    tank_o.y      <= tank_o.y - MOVE_STEP;
                    tank_o.facing <= DIR_UP;
                end
                DIR_RIGHT: if (!walls_i.right) begin
                    tank_o.x      <= tank_o.x + MOVE_STEP;
                    tank_o.facing <= DIR_RIGHT;
                end
                DIR_LEFT: if (!walls_i.left) begin
                    tank_o.x      <= tank_o.x - MOVE_STEP;
                    tank_o.facing <= DIR_LEFT;
                end
                default: ;  // stopped
            endcase
        end
    end

    a_facing_onehot: assert property (
        @(posedge clk_i) disable iff (reset_tank) $onehot(tank_o.facing));

endmodule

//--- hdl/wall_sensor.sv
// tank wall sensor
`timescale 1ns/1ps

module wall_sensor import tank_geom_pkg::*, tank_ctrl_pkg::*; (
    input  logic        clk_i,
    input  logic        reset_tank,
    input  scan_pos_t   scan_i,
    input  tank_state_t tank_i,
    input  dir_t        move_dir_i,
    input  logic        block_i,
    output wall_flags_t walls_o
);

    coord_t hofs, vofs, above, leftof;
    logic   h_span, v_span;
    logic   on_top, on_bottom, on_left, on_right;

    assign hofs   = scan_i.hpos - tank_i.x;
    assign vofs   = scan_i.vpos - tank_i.y;
    assign above  = tank_i.y - scan_i.vpos;
    assign leftof = tank_i.x - scan_i.hpos;

    // corners trimmed off each side
    assign h_span = (hofs > EDGE_MARGIN) && (hofs < BOX_LIMIT - EDGE_MARGIN);
    assign v_span = (vofs > EDGE_MARGIN) && (vofs < BOX_LIMIT - EDGE_MARGIN);

    assign on_top    = (above == 10'd1) && h_span;
    assign on_bottom = (vofs == TANK_SIZE) && h_span;
    assign on_left   = (leftof == 10'd1) && v_span;
    assign on_right  = (hofs == TANK_SIZE) && v_span;

    always_ff @(posedge clk_i or posedge reset_tank) begin
        if (reset_tank) begin
            walls_o <= '0;
        end else begin
            // new move forgets the other three sides
            if (move_dir_i != DIR_STOP) begin
                if (move_dir_i != DIR_UP)    walls_o.top    <= 1'b0;
                if (move_dir_i != DIR_DOWN)  walls_o.bottom <= 1'b0;
                if (move_dir_i != DIR_LEFT)  walls_o.left   <= 1'b0;
                if (move_dir_i != DIR_RIGHT) walls_o.right  <= 1'b0;
            end
            if (block_i) begin  // set wins
                if (on_top)    walls_o.top    <= 1'b1;
                if (on_bottom) walls_o.bottom <= 1'b1;
                if (on_left)   walls_o.left   <= 1'b1;
                if (on_right)  walls_o.right  <= 1'b1;
            end
        end
    end

    // first clock out of reset sets nothing without a blocking pixel
    a_walls_clear_after_reset: assert property (
        @(posedge clk_i) $fell(reset_tank) && !block_i |=> (walls_o == '0));

endmodule

//--- hdl/tank_ctrl_pkg.sv
// tank control types
package tank_ctrl_pkg;

    import tank_geom_pkg::*;

    localparam int COLOR_BITS = 24;

    typedef struct packed {
        logic top;
        logic bottom;
        logic left;
        logic right;
    } wall_flags_t;

    typedef struct packed {
        coord_t x;       // upper left corner
        coord_t y;
        dir_t   facing;
    } tank_state_t;

    typedef enum logic [1:0] {IDLE, FLYING, HIT} bullet_state_e;

    typedef enum logic [1:0] {PLAN, CHECK, DRIVE, SETTLE} pilot_state_e;

    typedef enum logic [1:0] {H_LEFT, H_RIGHT, H_UP, H_DOWN} pilot_heading_e;

    typedef struct packed {
        logic [COLOR_BITS/3-1:0] blue;
        logic [COLOR_BITS/3-1:0] green;
        logic [COLOR_BITS/3-1:0] red;
    } rgb_t;

endpackage

//--- hdl/tank_geom_pkg.sv
// tank geometry definitions
package tank_geom_pkg;

    typedef logic [9:0] coord_t;  // screen coordinate
    typedef logic [3:0] dir_t;    // one-hot, zero means stop
    typedef logic [4:0] sprite_ofs_t;

    localparam dir_t DIR_STOP  = 4'b0000;
    localparam dir_t DIR_DOWN  = 4'b0001;
    localparam dir_t DIR_UP    = 4'b0010;
    localparam dir_t DIR_RIGHT = 4'b0100;
    localparam dir_t DIR_LEFT  = 4'b1000;

    typedef struct packed {
        coord_t hpos;
        coord_t vpos;
    } scan_pos_t;

    localparam coord_t TANK_SIZE   = 10'd32;
    localparam coord_t BOX_LIMIT   = 10'd30;  // visible offsets 1..29
    localparam coord_t EDGE_MARGIN = 10'd2;
    localparam coord_t GRID        = 10'd16;
    localparam coord_t NOSE_OFS    = 10'd14;
    localparam coord_t BULLET_SIZE = 10'd5;
    localparam coord_t SCREEN_MID  = 10'd256;

    // same rom word, row/col order swaps with the facing axis
    typedef union packed {
        struct packed {sprite_ofs_t col; sprite_ofs_t row;} vert;
        struct packed {sprite_ofs_t row; sprite_ofs_t col;} horz;
    } sprite_addr_u;

endpackage
